//--- build.f
+incdir+bench
rtl/sched_pkg.sv
rtl/free_list.sv
rtl/excp_check.sv
rtl/rob_alloc_stage.sv
rtl/rename_alloc.sv
bench/tb_rename_alloc.sv

//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected ROB allocation request of one group
typedef struct packed {
  logic [DW-1:0]   slot_valid;
  areg_t [DW-1:0]  arch_dest;
  logic [DW-1:0]   preg_valid;
  preg_t [DW-1:0]  preg;
  logic [DW-1:0]   excp_valid;
  ecode_t [DW-1:0] ecode;
} group_t;

// free registers, next to allocate at the front
preg_t fl_model[$];
// allocated registers, oldest first
preg_t in_use[$];

function automatic void reset_model();
  fl_model.delete();
  in_use.delete();
  for (int k = ARCH_REGS; k < PHY_REGS; k++) begin
    fl_model.push_back(preg_t'(k));
  end
endfunction

// exception priority per slot, result is {valid, code}
function automatic logic [6:0] ref_excp(input logic slot_v, input logic has_int,
                                        input logic [1:0] plv, input instr_type_t typ,
                                        input misc_op_t op, input logic ev,
                                        input ecode_t ec, input logic inv);
  if (!slot_v) return 7'h0;
  if (has_int) return {1'b1, ECODE_INT};
  if (ev) return {1'b1, ec};
  if (inv) return {1'b1, ECODE_INE};
  if (typ == INSTR_PRIV && plv == PLV_USER) return {1'b1, ECODE_IPE};
  if (typ == INSTR_MISC && op == MISC_SYSCALL) return {1'b1, ECODE_SYS};
  if (typ == INSTR_MISC && op == MISC_BREAK) return {1'b1, ECODE_BRK};
  return 7'h0;
endfunction

// group on the request ports, pops the model in slot order
function automatic group_t predict_group();
  group_t g;
  g = '0;
  for (int i = 0; i < DW; i++) begin
    g.slot_valid[i] = req_slot_valid_i[i];
    g.arch_dest[i]  = req_arch_dest_i[i];
    {g.excp_valid[i], g.ecode[i]} = ref_excp(req_slot_valid_i[i], csr_has_int_i, csr_plv_i,
      req_instr_type_i[i], req_misc_op_i[i], req_excp_valid_i[i], req_excp_code_i[i],
      req_invalid_i[i]);
    if (req_slot_valid_i[i] && !req_excp_valid_i[i] && !req_invalid_i[i] &&
        req_arch_dest_i[i] != '0) begin
      g.preg_valid[i] = 1'b1;
      g.preg[i] = fl_model.pop_front();
      in_use.push_back(g.preg[i]);
    end
  end
  return g;
endfunction

`endif

//--- bench/tb_rename_alloc.sv
`timescale 1ns/10ps

module tb_rename_alloc import sched_pkg::*; ();

  localparam int DW        = 2;
  localparam int CW        = 2;
  localparam int ARCH_REGS = 32;
  localparam int PHY_REGS  = 64;
  localparam int N_DIRECT  = 6;
  localparam int N_RANDOM  = 300;
  localparam int N_REUSE   = 8;
  // exhaustion, hold and drain cycles on top of the groups
  localparam int STIM_CYCLES = N_DIRECT + N_RANDOM + N_REUSE + 60;
  localparam int WATCHDOG_NS = STIM_CYCLES * 20 + 1000;

  logic clk;
  logic rst_n;
  logic req_valid_i;
  logic req_ready_o;
  logic [DW-1:0] req_slot_valid_i;
  instr_type_t [DW-1:0] req_instr_type_i;
  misc_op_t [DW-1:0] req_misc_op_i;
  areg_t [DW-1:0] req_arch_dest_i;
  logic [DW-1:0] req_excp_valid_i;
  ecode_t [DW-1:0] req_excp_code_i;
  logic [DW-1:0] req_invalid_i;
  logic csr_has_int_i;
  logic [1:0] csr_plv_i;
  logic [CW-1:0] free_valid_i;
  preg_t [CW-1:0] free_preg_i;
  logic rob_valid_o;
  logic rob_ready_i;
  logic [DW-1:0] rob_slot_valid_o;
  areg_t [DW-1:0] rob_arch_dest_o;
  logic [DW-1:0] rob_preg_valid_o;
  preg_t [DW-1:0] rob_preg_o;
  logic [DW-1:0] rob_excp_valid_o;
  ecode_t [DW-1:0] rob_ecode_o;

  int stall_pct;
  int release_pct;

  `include "tb_model.svh"

  group_t exp_q[$];

  rename_alloc #(
    .DECODE_WIDTH (DW),
    .COMMIT_WIDTH (CW),
    .PHY_REG_NUM  (PHY_REGS),
    .ARCH_REG_NUM (ARCH_REGS)
  ) DUT (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s expected %0h, got %0h", $time, what, expected, actual);
      abort_run();
    end
  endtask

  task automatic set_slot(input int i, input logic v, input instr_type_t t, input misc_op_t op,
                          input areg_t d, input logic ev, input ecode_t ec, input logic inv);
    req_slot_valid_i[i] = v;
    req_instr_type_i[i] = t;
    req_misc_op_i[i]    = op;
    req_arch_dest_i[i]  = d;
    req_excp_valid_i[i] = ev;
    req_excp_code_i[i]  = ec;
    req_invalid_i[i]    = inv;
  endtask

  task automatic clear_group();
    for (int i = 0; i < DW; i++) begin
      set_slot(i, 1'b0, INSTR_ALU, MISC_NONE, '0, 1'b0, '0, 1'b0);
    end
  endtask

  task automatic randomize_group();
    for (int i = 0; i < DW; i++) begin
      set_slot(i, $urandom_range(0, 7) != 0, instr_type_t'($urandom_range(0, 3)),
               misc_op_t'($urandom_range(0, 2)),
               ($urandom_range(0, 3) == 0) ? areg_t'(0) : areg_t'($urandom),
               $urandom_range(0, 3) == 0, ecode_t'($urandom), $urandom_range(0, 7) == 0);
    end
    csr_has_int_i = ($urandom_range(0, 7) == 0);
    csr_plv_i     = 2'($urandom_range(0, 3));
  endtask

  // holds the group until the edge that transfers it
  task automatic send_group();
    int waited;
    waited = 0;
    req_valid_i = 1'b1;
    @(negedge clk);
    while (!req_ready_o) begin
      waited++;
      if (waited > 200) begin
        $display("request group was not accepted within 200 cycles");
        abort_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid_i = 1'b0;
  endtask

  // ============================================================
  // commit side and ROB back-pressure
  // ============================================================
  always @(posedge clk) begin
    logic [CW-1:0] rel_v;
    preg_t [CW-1:0] rel_p;
    logic rdy;
    // draw at the edge and drive 1 ns later
    for (int j = 0; j < CW; j++) begin
      if (rst_n && in_use.size() > 0 && $urandom_range(0, 99) < release_pct) begin
        rel_v[j] = 1'b1;
        rel_p[j] = in_use.pop_front();
      end else begin
        rel_v[j] = 1'b0;
        rel_p[j] = '0;
      end
    end
    rdy = ($urandom_range(0, 99) >= stall_pct);
    #1;
    free_valid_i = rel_v;
    free_preg_i  = rel_p;
    rob_ready_i  = rdy;
  end

  // ============================================================
  // comparison at mid-cycle where everything is settled
  // ============================================================
  always @(negedge clk) begin
    group_t g;
    if (rst_n) begin
      check_equal(rob_valid_o, exp_q.size() != 0, "rob_valid_o");
      check_equal(req_ready_o, fl_model.size() >= DW && (exp_q.size() == 0 || rob_ready_i),
                  "req_ready_o");
      if (rob_valid_o && rob_ready_i) begin
        g = exp_q.pop_front();
        for (int i = 0; i < DW; i++) begin
          check_equal(rob_slot_valid_o[i], g.slot_valid[i], $sformatf("slot %0d valid", i));
          check_equal(rob_arch_dest_o[i], g.arch_dest[i], $sformatf("slot %0d dest", i));
          check_equal(rob_preg_valid_o[i], g.preg_valid[i], $sformatf("slot %0d preg_v", i));
          if (g.preg_valid[i])
            check_equal(rob_preg_o[i], g.preg[i], $sformatf("slot %0d preg", i));
          check_equal(rob_excp_valid_o[i], g.excp_valid[i], $sformatf("slot %0d excp_v", i));
          if (g.excp_valid[i])
            check_equal(rob_ecode_o[i], g.ecode[i], $sformatf("slot %0d ecode", i));
        end
      end
      if (req_valid_i && req_ready_o) exp_q.push_back(predict_group());
      for (int j = 0; j < CW; j++) begin
        if (free_valid_i[j]) fl_model.push_back(free_preg_i[j]);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("simulation ran past its time limit, stopping");
    abort_run();
  end

  initial begin
    void'($urandom(32'h177d_ffe5));
    rst_n = 1'b0;
    req_valid_i = 1'b0;
    clear_group();
    csr_has_int_i = 1'b0;
    csr_plv_i = 2'd0;
    free_valid_i = '0;
    free_preg_i = '0;
    rob_ready_i = 1'b1;
    stall_pct = 0;
    release_pct = 0;
    reset_model();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // directed groups take registers from 32 upward
    set_slot(0, 1'b1, INSTR_ALU, MISC_NONE, 5'd5, 1'b0, '0, 1'b0);
    set_slot(1, 1'b1, INSTR_MEM, MISC_NONE, 5'd7, 1'b0, '0, 1'b0);
    send_group();
    set_slot(0, 1'b1, INSTR_ALU, MISC_NONE, 5'd0, 1'b0, '0, 1'b0);
    set_slot(1, 1'b1, INSTR_ALU, MISC_NONE, 5'd3, 1'b0, '0, 1'b0);
    send_group();
    set_slot(0, 1'b1, INSTR_MEM, MISC_NONE, 5'd4, 1'b1, 6'h08, 1'b0);
    set_slot(1, 1'b1, INSTR_ALU, MISC_NONE, 5'd6, 1'b0, '0, 1'b1);
    send_group();
    csr_plv_i = PLV_USER;
    set_slot(0, 1'b1, INSTR_PRIV, MISC_NONE, 5'd2, 1'b0, '0, 1'b0);
    set_slot(1, 1'b1, INSTR_MISC, MISC_SYSCALL, 5'd1, 1'b0, '0, 1'b0);
    send_group();
    csr_plv_i = 2'd0;
    set_slot(1, 1'b1, INSTR_MISC, MISC_BREAK, 5'd8, 1'b0, '0, 1'b0);
    send_group();
    csr_has_int_i = 1'b1;
    send_group();

    // random fields with stalls and releases
    stall_pct = 30;
    release_pct = 40;
    repeat (N_RANDOM) begin
      randomize_group();
      send_group();
    end

    // ============================================================
    // exhaustion then reuse of released registers
    // ============================================================
    stall_pct = 0;
    release_pct = 0;
    csr_has_int_i = 1'b0;
    clear_group();
    set_slot(0, 1'b1, INSTR_ALU, MISC_NONE, 5'd9, 1'b0, '0, 1'b0);
    set_slot(1, 1'b1, INSTR_ALU, MISC_NONE, 5'd10, 1'b0, '0, 1'b0);
    repeat (3) @(posedge clk);
    #1;
    while (fl_model.size() >= DW) send_group();
    req_valid_i = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    release_pct = 100;
    send_group();
    repeat (N_REUSE) send_group();

    repeat (20) @(posedge clk);
    $display("Test passed");
    $finish;
  end

endmodule

//--- rtl/rename_alloc.sv
`timescale 1ns/10ps

module rename_alloc import sched_pkg::*; #(
  parameter int DECODE_WIDTH = sched_pkg::DECODE_WIDTH,
  parameter int COMMIT_WIDTH = sched_pkg::COMMIT_WIDTH,
  parameter int PHY_REG_NUM  = sched_pkg::PHY_REG_NUM,
  parameter int ARCH_REG_NUM = sched_pkg::ARCH_REG_NUM
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // request group
  input  logic                           req_valid_i,
  output logic                           req_ready_o,
  input  logic [DECODE_WIDTH-1:0]        req_slot_valid_i,
  input  instr_type_t [DECODE_WIDTH-1:0] req_instr_type_i,
  input  misc_op_t [DECODE_WIDTH-1:0]    req_misc_op_i,
  input  areg_t [DECODE_WIDTH-1:0]       req_arch_dest_i,
  input  logic [DECODE_WIDTH-1:0]        req_excp_valid_i,
  input  ecode_t [DECODE_WIDTH-1:0]      req_excp_code_i,
  input  logic [DECODE_WIDTH-1:0]        req_invalid_i,
  // csr state
  input  logic                           csr_has_int_i,
  input  logic [1:0]                     csr_plv_i,
  // release from commit
  input  logic [COMMIT_WIDTH-1:0]        free_valid_i,
  input  preg_t [COMMIT_WIDTH-1:0]       free_preg_i,
  // ROB allocation request
  output logic                           rob_valid_o,
  input  logic                           rob_ready_i,
  output logic [DECODE_WIDTH-1:0]        rob_slot_valid_o,
  output areg_t [DECODE_WIDTH-1:0]       rob_arch_dest_o,
  output logic [DECODE_WIDTH-1:0]        rob_preg_valid_o,
  output preg_t [DECODE_WIDTH-1:0]       rob_preg_o,
  output logic [DECODE_WIDTH-1:0]        rob_excp_valid_o,
  output ecode_t [DECODE_WIDTH-1:0]      rob_ecode_o
);

  logic accept;
  logic can_alloc;

  free_list #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH),
    .PHY_REG_NUM  (PHY_REG_NUM),
    .ARCH_REG_NUM (ARCH_REG_NUM)
  ) u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept_i     (accept),
    .slot_valid_i (req_slot_valid_i),
    .excp_valid_i (req_excp_valid_i),
    .invalid_i    (req_invalid_i),
    .arch_dest_i  (req_arch_dest_i),
    .free_valid_i (free_valid_i),
    .free_preg_i  (free_preg_i),
    .can_alloc_o  (can_alloc),
    .preg_valid_o (rob_preg_valid_o),
    .preg_o       (rob_preg_o)
  );

  excp_check #(
    .DECODE_WIDTH (DECODE_WIDTH)
  ) u_excp_check (
    .clk           (clk),
    .rst_n         (rst_n),
    .accept_i      (accept),
    .slot_valid_i  (req_slot_valid_i),
    .instr_type_i  (req_instr_type_i),
    .misc_op_i     (req_misc_op_i),
    .excp_valid_i  (req_excp_valid_i),
    .excp_code_i   (req_excp_code_i),
    .invalid_i     (req_invalid_i),
    .arch_dest_i   (req_arch_dest_i),
    .csr_has_int_i (csr_has_int_i),
    .csr_plv_i     (csr_plv_i),
    .slot_valid_o  (rob_slot_valid_o),
    .arch_dest_o   (rob_arch_dest_o),
    .excp_valid_o  (rob_excp_valid_o),
    .ecode_o       (rob_ecode_o)
  );

  rob_alloc_stage u_rob_alloc_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .can_alloc_i (can_alloc),
    .rob_ready_i (rob_ready_i),
    .req_ready_o (req_ready_o),
    .accept_o    (accept),
    .rob_valid_o (rob_valid_o)
  );

endmodule

//--- rtl/rob_alloc_stage.sv
`timescale 1ns/10ps

module rob_alloc_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic req_valid_i,
  input  logic can_alloc_i,
  input  logic rob_ready_i,
  output logic req_ready_o,
  output logic accept_o,
  output logic rob_valid_o
);

  logic rob_valid_q;
  logic out_free;
  logic leave;

  // ============================================================
  // handshake on the request side
  // ============================================================

  // output register is free if empty or draining this cycle
  assign out_free    = ~rob_valid_q | rob_ready_i;
  assign req_ready_o = can_alloc_i & out_free;
  assign accept_o    = req_valid_i & req_ready_o;

  // group handed to the ROB on this edge
  assign leave = rob_valid_q & rob_ready_i;

  // ============================================================
  // output occupancy
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rob_valid_q <= 1'b0;
    end else if (accept_o) begin
      // new group replaces any leaving one
      rob_valid_q <= 1'b1;
    end else if (leave) begin
      rob_valid_q <= 1'b0;
    end
  end

  /*
   * the payload registers in free_list and excp_check load only
   * on accept_o, so a stalled group holds until rob_ready_i
   */
  assign rob_valid_o = rob_valid_q;

endmodule

//--- rtl/excp_check.sv
`timescale 1ns/10ps

module excp_check import sched_pkg::*; #(
  parameter int DECODE_WIDTH = sched_pkg::DECODE_WIDTH
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          accept_i,
  input  logic [DECODE_WIDTH-1:0]       slot_valid_i,
  input  instr_type_t [DECODE_WIDTH-1:0] instr_type_i,
  input  misc_op_t [DECODE_WIDTH-1:0]   misc_op_i,
  input  logic [DECODE_WIDTH-1:0]       excp_valid_i,
  input  ecode_t [DECODE_WIDTH-1:0]     excp_code_i,
  input  logic [DECODE_WIDTH-1:0]       invalid_i,
  input  areg_t [DECODE_WIDTH-1:0]      arch_dest_i,
  input  logic                          csr_has_int_i,
  input  logic [1:0]                    csr_plv_i,
  output logic [DECODE_WIDTH-1:0]       slot_valid_o,
  output areg_t [DECODE_WIDTH-1:0]      arch_dest_o,
  output logic [DECODE_WIDTH-1:0]       excp_valid_o,
  output ecode_t [DECODE_WIDTH-1:0]     ecode_o
);

  logic [DECODE_WIDTH-1:0]        slot_valid_q;
  instr_type_t [DECODE_WIDTH-1:0] instr_type_q;
  misc_op_t [DECODE_WIDTH-1:0]    misc_op_q;
  logic [DECODE_WIDTH-1:0]        excp_valid_q;
  ecode_t [DECODE_WIDTH-1:0]      excp_code_q;
  logic [DECODE_WIDTH-1:0]        invalid_q;
  areg_t [DECODE_WIDTH-1:0]       arch_dest_q;
  logic                           has_int_q;
  logic [1:0]                     plv_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid_q <= '0;
    end else if (accept_i) begin
      slot_valid_q <= slot_valid_i;
    end
  end

  // slot fields and csr state sampled with the group
  always_ff @(posedge clk) begin
    if (accept_i) begin
      instr_type_q <= instr_type_i;
      misc_op_q    <= misc_op_i;
      excp_valid_q <= excp_valid_i;
      excp_code_q  <= excp_code_i;
      invalid_q    <= invalid_i;
      arch_dest_q  <= arch_dest_i;
      has_int_q    <= csr_has_int_i;
      plv_q        <= csr_plv_i;
    end
  end

  // ============================================================
  // fixed priority, interrupt first
  // ============================================================
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      excp_valid_o[i] = 1'b1;
      ecode_o[i]      = ECODE_INT;
      if (!slot_valid_q[i]) begin
        excp_valid_o[i] = 1'b0;
      end else if (has_int_q) begin
        ecode_o[i] = ECODE_INT;
      end else if (excp_valid_q[i]) begin
        ecode_o[i] = excp_code_q[i];
      end else if (invalid_q[i]) begin
        ecode_o[i] = ECODE_INE;
      end else if (instr_type_q[i] == INSTR_PRIV && plv_q == PLV_USER) begin
        ecode_o[i] = ECODE_IPE;
      end else if (instr_type_q[i] == INSTR_MISC && misc_op_q[i] == MISC_SYSCALL) begin
        ecode_o[i] = ECODE_SYS;
      end else if (instr_type_q[i] == INSTR_MISC && misc_op_q[i] == MISC_BREAK) begin
        ecode_o[i] = ECODE_BRK;
      end else begin
        excp_valid_o[i] = 1'b0;
      end
    end
  end

  assign slot_valid_o = slot_valid_q;
  assign arch_dest_o  = arch_dest_q;

endmodule

//--- rtl/free_list.sv
`timescale 1ns/10ps

module free_list import sched_pkg::*; #(
  parameter int DECODE_WIDTH = sched_pkg::DECODE_WIDTH,
  parameter int COMMIT_WIDTH = sched_pkg::COMMIT_WIDTH,
  parameter int PHY_REG_NUM  = sched_pkg::PHY_REG_NUM,
  parameter int ARCH_REG_NUM = sched_pkg::ARCH_REG_NUM
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 accept_i,
  input  logic [DECODE_WIDTH-1:0]              slot_valid_i,
  input  logic [DECODE_WIDTH-1:0]              excp_valid_i,
  input  logic [DECODE_WIDTH-1:0]              invalid_i,
  input  areg_t [DECODE_WIDTH-1:0]             arch_dest_i,
  input  logic [COMMIT_WIDTH-1:0]              free_valid_i,
  input  preg_t [COMMIT_WIDTH-1:0]             free_preg_i,
  output logic                                 can_alloc_o,
  output logic [DECODE_WIDTH-1:0]              preg_valid_o,
  output preg_t [DECODE_WIDTH-1:0]             preg_o
);

  localparam int FL_DEPTH = PHY_REG_NUM - ARCH_REG_NUM;
  localparam int PTR_W    = $clog2(FL_DEPTH);
  localparam int CNT_W    = $clog2(FL_DEPTH + 1);

  preg_t                          fl_q [FL_DEPTH];
  logic [PTR_W-1:0]               head_q;
  logic [PTR_W-1:0]               tail_q;
  logic [CNT_W-1:0]               count_q;
  logic [DECODE_WIDTH-1:0]        need;
  preg_t [DECODE_WIDTH-1:0]       pop_preg;
  logic [CNT_W-1:0]               pop_cnt;
  logic [CNT_W-1:0]               push_cnt;
  logic [COMMIT_WIDTH-1:0][PTR_W-1:0] push_idx;
  logic [DECODE_WIDTH-1:0]        preg_valid_q;
  preg_t [DECODE_WIDTH-1:0]       preg_q;

  // circular pointer advance
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                               input int unsigned ofs);
    int unsigned sum;
    sum = ptr + ofs;
    if (sum >= FL_DEPTH) begin
      sum = sum - FL_DEPTH;
    end
    return PTR_W'(sum);
  endfunction

  assign can_alloc_o = (count_q >= CNT_W'(DECODE_WIDTH));

  // ============================================================
  // slot demand and release positions
  // ============================================================
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      need[i] = slot_valid_i[i] & ~excp_valid_i[i] & ~invalid_i[i] & (|arch_dest_i[i]);
      // earlier needing slots take the entries before this one
      pop_preg[i] = fl_q[ptr_add(head_q, pop_cnt)];
      pop_cnt = pop_cnt + CNT_W'(need[i]);
    end
    push_cnt = '0;
    for (int j = 0; j < COMMIT_WIDTH; j++) begin
      push_idx[j] = ptr_add(tail_q, push_cnt);
      push_cnt = push_cnt + CNT_W'(free_valid_i[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < FL_DEPTH; k++) begin
        fl_q[k] <= preg_t'(ARCH_REG_NUM + k);
      end
    end else begin
      for (int j = 0; j < COMMIT_WIDTH; j++) begin
        if (free_valid_i[j]) begin
          fl_q[push_idx[j]] <= free_preg_i[j];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q       <= '0;
      // list starts full, so tail has wrapped onto head
      tail_q       <= '0;
      count_q      <= CNT_W'(FL_DEPTH);
      preg_valid_q <= '0;
    end else begin
      tail_q  <= ptr_add(tail_q, push_cnt);
      count_q <= count_q + push_cnt - (accept_i ? pop_cnt : '0);
      if (accept_i) begin
        head_q       <= ptr_add(head_q, pop_cnt);
        preg_valid_q <= need;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept_i) begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        preg_q[i] <= need[i] ? pop_preg[i] : '0;
      end
    end
  end

  assign preg_valid_o = preg_valid_q;
  assign preg_o       = preg_q;

endmodule

//--- rtl/sched_pkg.sv
package sched_pkg;

  // ============================================================
  // default sizes, overridden through the top-level parameters
  // ============================================================
  localparam int DECODE_WIDTH = 2;
  localparam int COMMIT_WIDTH = 2;
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 64;

  // register indices
  typedef logic [$clog2(PHY_REG_NUM)-1:0]  preg_t;
  typedef logic [$clog2(ARCH_REG_NUM)-1:0] areg_t;

  // ============================================================
  // instruction classes
  // ============================================================
  typedef enum logic [1:0] {
    INSTR_ALU  = 2'd0,
    INSTR_MEM  = 2'd1,
    INSTR_MISC = 2'd2,
    INSTR_PRIV = 2'd3
  } instr_type_t;

  // only meaningful when the class is MISC
  typedef enum logic [1:0] {
    MISC_NONE    = 2'd0,
    MISC_SYSCALL = 2'd1,
    MISC_BREAK   = 2'd2
  } misc_op_t;

  // ============================================================
  // exception codes
  // ============================================================
  typedef logic [5:0] ecode_t;

  localparam ecode_t ECODE_INT = 6'h00;
  localparam ecode_t ECODE_SYS = 6'h0B;
  localparam ecode_t ECODE_BRK = 6'h0C;
  localparam ecode_t ECODE_INE = 6'h0D;
  localparam ecode_t ECODE_IPE = 6'h0E;

  // lowest privilege level, privileged instructions trap here
  localparam logic [1:0] PLV_USER = 2'd3;

endpackage
